// ==== common/bridgePkg.sv ====
// ========================================================================
// bridge widths, APB address map, AHB and APB types, slave decode
// ========================================================================
`default_nettype none

package bridgePkg;

	localparam int addrWidth = 32;
	localparam int dataWidth = 32;
	localparam int selWidth = 3;                                // one select line per APB slave

	localparam logic [addrWidth-1:0] slaveBase = 32'h8000_0000;
	localparam logic [addrWidth-1:0] slaveWindow = 32'h0400_0000; // 64 MB for each slave
	localparam int windowBits = $clog2(slaveWindow);

	typedef enum logic [1:0] {
		transIdle = 2'b00,
		transBusy = 2'b01,
		transNonseq = 2'b10,
		transSeq = 2'b11
	} htransType;

	typedef enum logic [2:0] {
		stIdle = 3'b000,
		stWwait = 3'b001,
		stRead = 3'b010,
		stWrite = 3'b011,
		stWriteP = 3'b100,
		stREnable = 3'b101,
		stWEnable = 3'b110,
		stWEnableP = 3'b111
	} bridgeState;

	typedef struct packed {
		logic [addrWidth-1:0] addr;
		logic write;
		logic [dataWidth-1:0] wdata;
	} ahbPhase;

	typedef struct packed {
		logic [addrWidth-1:0] paddr;
		logic [dataWidth-1:0] pwdata;
		logic pwrite;
		logic penable;
		logic [selWidth-1:0] psel;
	} apbBus;

	// one-hot window select, all zero outside the map
	function automatic logic [selWidth-1:0] decodeSel(input logic [addrWidth-1:0] addr);
		logic [addrWidth-1:0] offset;
		logic [selWidth-1:0] sel;
		offset = addr - slaveBase;                              // below the base this wraps far above the map
		sel = '0;
		for (int i = 0; i < selWidth; i++)
		begin
			if ((offset >> windowBits) == i)
				sel[i] = 1'b1;
		end
		return sel;
	endfunction

endpackage

`default_nettype wire

// ==== source/ahbSlaveInterface.sv ====
// ========================================================================
// AHB slave side: address decode, transfer qualification, phase assembly
// ========================================================================
`timescale 1ns/100ps
`default_nettype none

module ahbSlaveInterface (
	input wire logic Hclk,
	input wire logic Hresetn,
	input wire logic [bridgePkg::addrWidth-1:0] Haddr,
	input wire logic [bridgePkg::dataWidth-1:0] Hwdata,
	input wire logic Hwrite,
	input wire logic Hreadyin,
	input wire bridgePkg::htransType Htrans,
	output bridgePkg::ahbPhase curPhase,
	output logic valid,
	output logic [bridgePkg::selWidth-1:0] tempSel
);

	logic activeTrans;
	logic wrDataPhase;

	// ====================================================================
	// address phase decode
	// ====================================================================

	assign tempSel = bridgePkg::decodeSel(Haddr);

	assign activeTrans = (Htrans == bridgePkg::transNonseq) ||
		(Htrans == bridgePkg::transSeq);                         // idle and busy carry no transfer

	assign valid = Hreadyin && activeTrans && (|tempSel);

	// ====================================================================
	// data phase tracking
	// ====================================================================

	// set while the bus carries the data beat of an accepted write
	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
			wrDataPhase <= 1'b0;
		else if (Hreadyin)
			wrDataPhase <= valid && Hwrite;                     // held through a stalled data phase
	end

	always_comb
	begin
		curPhase.addr = Haddr;
		curPhase.write = Hwrite;
		curPhase.wdata = wrDataPhase ? Hwdata : '0;            // only real write data goes downstream
	end

endmodule

`default_nettype wire

// ==== source/transferPipe.sv ====
// ========================================================================
// two-stage transfer pipeline behind the AHB slave interface
// ========================================================================
`timescale 1ns/100ps
`default_nettype none

module transferPipe (
	input wire logic Hclk,
	input wire logic Hresetn,
	input wire logic Hreadyin,
	input wire bridgePkg::ahbPhase curPhase,
	output bridgePkg::ahbPhase pipe1,
	output bridgePkg::ahbPhase pipe2,
	output logic writeReg
);

	// stage one follows the address bus, so a held address phase is captured again
	// each cycle; its write flag is kept only for a phase the bus actually accepts
	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			pipe1 <= '0;
			pipe2 <= '0;
		end
		else
		begin
			pipe1.addr <= curPhase.addr;
			pipe1.write <= curPhase.write && Hreadyin;
			if (Hreadyin)
				pipe1.wdata <= curPhase.wdata;                  // last completed data beat

			pipe2.addr <= pipe1.addr;
			pipe2.write <= pipe1.write;
			pipe2.wdata <= curPhase.wdata;                      // data arrives one cycle after its address
		end
	end

	assign writeReg = pipe1.write;

endmodule

`default_nettype wire

// ==== apbController/apbController.sv ====
// ========================================================================
// APB state machine: setup and enable sequencing, Hreadyout stall
// ========================================================================
`timescale 1ns/100ps
`default_nettype none

module apbController (
	input wire logic Hclk,
	input wire logic Hresetn,
	input wire logic valid,
	input wire logic Hwrite,
	input wire logic writeReg,
	input wire logic [bridgePkg::addrWidth-1:0] curAddr,
	input wire bridgePkg::ahbPhase pipe1,
	input wire bridgePkg::ahbPhase pipe2,
	input wire logic [bridgePkg::dataWidth-1:0] Hwdata,
	input wire logic [bridgePkg::selWidth-1:0] tempSel,
	output bridgePkg::apbBus apbOut,
	output logic Hreadyout
);

	bridgePkg::bridgeState state;
	bridgePkg::bridgeState nextState;
	bridgePkg::apbBus nextApb;
	logic nextReady;

	// request fields of one APB setup cycle
	function automatic bridgePkg::apbBus setupPhase(
		input logic [bridgePkg::addrWidth-1:0] addr,
		input logic [bridgePkg::dataWidth-1:0] data,
		input logic write,
		input logic [bridgePkg::selWidth-1:0] sel
	);
		bridgePkg::apbBus bus;
		bus.paddr = addr;
		bus.pwdata = data;
		bus.pwrite = write;
		bus.penable = 1'b0;
		bus.psel = sel;
		return bus;
	endfunction

	// ====================================================================
	// next state and next outputs
	// ====================================================================

	always_comb
	begin
		nextState = state;
		nextApb = apbOut;
		nextReady = Hreadyout;

		case (state)
			// APB bus free, the bridge can accept a new address phase
			bridgePkg::stIdle,
			bridgePkg::stREnable,
			bridgePkg::stWEnable:
			begin
				nextApb.psel = '0;
				nextApb.penable = 1'b0;
				nextReady = 1'b1;
				if (valid && Hwrite)
					nextState = bridgePkg::stWwait;             // write data comes next cycle
				else if (valid)
				begin
					nextState = bridgePkg::stRead;
					nextApb = setupPhase(curAddr, apbOut.pwdata, 1'b0, tempSel);
					nextReady = 1'b0;
				end
				else
					nextState = bridgePkg::stIdle;
			end

			bridgePkg::stWwait:
			begin
				nextApb = setupPhase(pipe1.addr, Hwdata, 1'b1,
					bridgePkg::decodeSel(pipe1.addr));
				nextReady = 1'b0;
				if (valid)
					nextState = bridgePkg::stWriteP;            // another phase accepted behind this write
				else
					nextState = bridgePkg::stWrite;
			end

			bridgePkg::stRead:
			begin
				nextApb.penable = 1'b1;
				nextReady = 1'b1;                               // read data returns in the enable cycle
				nextState = bridgePkg::stREnable;
			end

			bridgePkg::stWrite:
			begin
				nextApb.penable = 1'b1;
				nextReady = 1'b1;
				if (valid)
					nextState = bridgePkg::stWEnableP;
				else
					nextState = bridgePkg::stWEnable;
			end

			bridgePkg::stWriteP:
			begin
				nextApb.penable = 1'b1;
				nextReady = writeReg;                           // a pending read keeps the master waiting
				nextState = bridgePkg::stWEnableP;
			end

			// the pending transfer sits in stage two and starts right after this enable
			bridgePkg::stWEnableP:
			begin
				nextApb = setupPhase(pipe2.addr, pipe2.wdata, pipe2.write,
					bridgePkg::decodeSel(pipe2.addr));
				nextReady = 1'b0;
				if (!pipe2.write)
					nextState = bridgePkg::stRead;
				else if (valid)
					nextState = bridgePkg::stWriteP;
				else
					nextState = bridgePkg::stWrite;
			end

			default:
			begin
				nextApb.psel = '0;
				nextApb.penable = 1'b0;
				nextReady = 1'b1;
				nextState = bridgePkg::stIdle;
			end
		endcase
	end

	// ====================================================================
	// state and output registers
	// ====================================================================

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			state <= bridgePkg::stIdle;
			apbOut <= '0;
			Hreadyout <= 1'b1;
		end
		else
		begin
			state <= nextState;
			apbOut <= nextApb;
			Hreadyout <= nextReady;
		end
	end

endmodule

`default_nettype wire

// ==== source/ahbApbBridge.sv ====
// ========================================================================
// AHB-Lite to APB bridge top level
// ========================================================================
`timescale 1ns/100ps
`default_nettype none

module ahbApbBridge (
	input wire logic Hclk,
	input wire logic Hresetn,
	input wire logic [bridgePkg::addrWidth-1:0] Haddr,
	input wire logic [bridgePkg::dataWidth-1:0] Hwdata,
	input wire logic Hwrite,
	input wire logic Hreadyin,
	input wire bridgePkg::htransType Htrans,
	input wire logic [bridgePkg::dataWidth-1:0] Prdata,
	output logic [bridgePkg::dataWidth-1:0] Hrdata,
	output logic Hreadyout,
	output bridgePkg::apbBus apbOut
);

	bridgePkg::ahbPhase curPhase;
	bridgePkg::ahbPhase pipe1;
	bridgePkg::ahbPhase pipe2;
	logic valid;
	logic writeReg;
	logic [bridgePkg::selWidth-1:0] tempSel;

	ahbSlaveInterface slaveIf (
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.Haddr(Haddr),
		.Hwdata(Hwdata),
		.Hwrite(Hwrite),
		.Hreadyin(Hreadyin),
		.Htrans(Htrans),
		.curPhase(curPhase),
		.valid(valid),
		.tempSel(tempSel)
	);

	transferPipe pipe (
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.Hreadyin(Hreadyin),
		.curPhase(curPhase),
		.pipe1(pipe1),
		.pipe2(pipe2),
		.writeReg(writeReg)
	);

	apbController ctrl (
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.valid(valid),
		.Hwrite(curPhase.write),
		.writeReg(writeReg),
		.curAddr(curPhase.addr),
		.pipe1(pipe1),
		.pipe2(pipe2),
		.Hwdata(curPhase.wdata),
		.tempSel(tempSel),
		.apbOut(apbOut),
		.Hreadyout(Hreadyout)
	);

	assign Hrdata = Prdata;                                     // sampled by the master in the enable cycle

endmodule

`default_nettype wire

// ==== sim/apbSlaveModel.sv ====
// ==========================================================================
// APB peripheral model: three slaves with 16 words each
// ==========================================================================
`timescale 1ns/100ps
`default_nettype none

module apbSlaveModel (
	input wire logic Hclk,
	input wire logic Hresetn,
	input wire bridgePkg::apbBus apbOut,
	output logic [31:0] Prdata
);

	logic [31:0] mem [0:47];
	logic [47:0] written;
	logic [5:0] idx;
	logic selected;

	assign selected = |apbOut.psel;

	always_comb
	begin
		idx = {2'b00, apbOut.paddr[5:2]};
		if (apbOut.psel[1])
			idx = idx + 6'd16;
		else if (apbOut.psel[2])
			idx = idx + 6'd32;                                  // slave 0 keeps the low 16 words
	end

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
			written <= '0;
		else if (selected && apbOut.penable && apbOut.pwrite)
		begin
			mem[idx] <= apbOut.pwdata;
			written[idx] <= 1'b1;
		end
	end

	// an unwritten word answers with its own address scrambled
	assign Prdata = !selected ? '0 :
		written[idx] ? mem[idx] : apbOut.paddr ^ 32'ha5a5a5a5;

endmodule

`default_nettype wire

// ==== sim/bridgeTb.sv ====
// ==========================================================================
// AHB master stimulus, APB scoreboard and protocol checks for the bridge
// ==========================================================================
`timescale 1ns/100ps
`default_nettype none

module bridgeTb;

	typedef struct packed {
		logic [31:0] addr;
		logic write;
		logic [31:0] data;
		logic [2:0] sel;
		logic [31:0] acceptCycle;
	} expTransfer;

	logic Hclk;
	logic Hresetn;
	logic [31:0] Haddr;
	logic [31:0] Hwdata;
	logic Hwrite;
	bridgePkg::htransType Htrans;
	logic [31:0] Prdata;
	logic [31:0] Hrdata;
	logic Hreadyout;
	bridgePkg::apbBus apbOut;
	bridgePkg::apbBus setupBus;

	integer seed;
	int errors;
	int checks;
	logic timedOut;
	logic prevSetup;
	logic idleCheck;
	logic [31:0] cycle;
	expTransfer expQ[$];
	logic [31:0] wrAddrs[$];
	logic [31:0] mirror [0:2][0:15];
	logic written [0:2][0:15];

	ahbApbBridge dut (
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.Haddr(Haddr),
		.Hwdata(Hwdata),
		.Hwrite(Hwrite),
		.Hreadyin(Hreadyout),                                   // master sees its own stall
		.Htrans(Htrans),
		.Prdata(Prdata),
		.Hrdata(Hrdata),
		.Hreadyout(Hreadyout),
		.apbOut(apbOut)
	);

	apbSlaveModel apbMem (
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.apbOut(apbOut),
		.Prdata(Prdata)
	);

	initial
	begin
		Hclk = 1'b0;
		forever #4 Hclk = ~Hclk;
	end

	always @(posedge Hclk)
	begin
		if (!Hresetn)
			cycle <= '0;
		else
			cycle <= cycle + 1;
	end

	// ======================================================================
	// checks
	// ======================================================================

	task checkValue(input string name, input logic [31:0] got, input logic [31:0] want);
		checks++;
		assert (got === want)
		else
		begin
			errors++;
			$display("ERR %s: got %h expected %h", name, got, want);
		end
	endtask

	task checkSetup;
		expTransfer front;
		assert (!prevSetup)
		else
		begin
			errors++;
			$display("setup cycle was not followed by an enable cycle");
		end
		if (expQ.size() == 0)
		begin
			errors++;
			$display("psel %h raised with no transfer expected", apbOut.psel);
		end
		else
		begin
			front = expQ[0];
			checkValue("paddr", apbOut.paddr, front.addr);
			checkValue("psel", 32'(apbOut.psel), 32'(front.sel));
			checkValue("pwrite", 32'(apbOut.pwrite), 32'(front.write));
			checkValue("Hreadyout", 32'(Hreadyout), 32'd0);
			if (front.write)
				checkValue("pwdata", apbOut.pwdata, front.data);
			else
				checkValue("read setup cycle", cycle, front.acceptCycle + 1);
		end
		setupBus = apbOut;
		prevSetup = 1'b1;
	endtask

	task checkEnable;
		expTransfer front;
		if (!prevSetup)
		begin
			errors++;
			$display("penable rose without a setup cycle before it");
		end
		else
		begin
			checkValue("paddr hold", apbOut.paddr, setupBus.paddr);
			checkValue("pwdata hold", apbOut.pwdata, setupBus.pwdata);
			checkValue("pwrite hold", 32'(apbOut.pwrite), 32'(setupBus.pwrite));
			checkValue("psel hold", 32'(apbOut.psel), 32'(setupBus.psel));
			if (expQ.size() > 0)
			begin
				front = expQ.pop_front();
				if (!front.write)
				begin
					checkValue("Hrdata", Hrdata, front.data);
					checkValue("Hreadyout", 32'(Hreadyout), 32'd1);
				end
			end
		end
		prevSetup = 1'b0;
	endtask

	always @(negedge Hclk)
	begin
		if (Hresetn)
		begin
			if (idleCheck)
				checkValue("{psel,penable,Hreadyout}",
					32'({apbOut.psel, apbOut.penable, Hreadyout}), 32'h1);
			if (apbOut.psel != 0 && !apbOut.penable)
				checkSetup();
			else if (apbOut.penable)
				checkEnable();
			else
			begin
				assert (!prevSetup)
				else
				begin
					errors++;
					$display("setup cycle ended without an enable cycle");
				end
				prevSetup = 1'b0;
			end
		end
	end

	// ======================================================================
	// AHB master
	// ======================================================================

	task waitReady;
		int count;
		count = 0;
		@(negedge Hclk);
		while (!Hreadyout && !timedOut)
		begin
			count++;
			if (count > 40)
			begin
				errors++;
				$display("timeout while the bridge held Hreadyout low");
				timedOut = 1'b1;
			end
			else
				@(negedge Hclk);
		end
	endtask

	// expected APB transfer with read data taken from the scoreboard's memory image
	task pushTransfer(input logic [31:0] addr, input logic write, input logic [31:0] data);
		expTransfer t;
		int slave;
		slave = (addr - bridgePkg::slaveBase) / bridgePkg::slaveWindow;
		t.addr = addr;
		t.write = write;
		t.sel = 3'b001 << slave;
		t.acceptCycle = cycle;
		if (write)
		begin
			mirror[slave][addr[5:2]] = data;
			written[slave][addr[5:2]] = 1'b1;
			t.data = data;
		end
		else
			t.data = written[slave][addr[5:2]] ? mirror[slave][addr[5:2]] :
				addr ^ 32'ha5a5a5a5;
		expQ.push_back(t);
	endtask

	// one address phase while busData completes the previous data phase
	task issue(input logic [31:0] addr, input logic write, input bridgePkg::htransType trans,
		input logic [31:0] busData, input logic [31:0] wdata);
		logic mapped;
		mapped = (addr - bridgePkg::slaveBase) < 3 * bridgePkg::slaveWindow;
		@(posedge Hclk);
		Haddr <= addr;
		Hwrite <= write;
		Htrans <= trans;
		Hwdata <= busData;
		waitReady();
		if (mapped && (trans == bridgePkg::transNonseq || trans == bridgePkg::transSeq))
			pushTransfer(addr, write, wdata);
	endtask

	task settle(input logic [31:0] busData);
		int count;
		count = 0;
		@(posedge Hclk);
		Htrans <= bridgePkg::transIdle;
		Hwdata <= busData;
		@(negedge Hclk);
		while (!timedOut && (expQ.size() != 0 || apbOut.psel != 0 || !Hreadyout))
		begin
			count++;
			if (count > 40)
			begin
				errors++;
				$display("timeout while expected APB transfers were still pending");
				timedOut = 1'b1;
			end
			else
				@(negedge Hclk);
		end
		repeat (2) @(negedge Hclk);                           // a stray psel would show up here
	endtask

	function logic [31:0] randAddr();
		logic [31:0] r;
		r = $random(seed);
		return bridgePkg::slaveBase + (r % 3) * bridgePkg::slaveWindow +
			($random(seed) & 32'h03ff_fffc);
	endfunction

	task endRun;
		$display("checks %0d, errors %0d, pending %0d", checks, errors, expQ.size());
		if (errors == 0 && !timedOut && expQ.size() == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	endtask

	initial
	begin
		wait (timedOut);
		endRun();
	end

	initial
	begin
		logic [31:0] a1;
		logic [31:0] d1;
		logic [31:0] d2;
		seed = 32'hd9d0;
		errors = 0;
		checks = 0;
		timedOut = 1'b0;
		prevSetup = 1'b0;
		idleCheck = 1'b0;
		Hresetn = 1'b0;
		Haddr = '0;
		Hwdata = '0;
		Hwrite = 1'b0;
		Htrans = bridgePkg::transIdle;
		foreach (written[i, j])
			written[i][j] = 1'b0;
		repeat (2) @(posedge Hclk);
		Hresetn <= 1'b1;
		idleCheck = 1'b1;
		repeat (6) @(posedge Hclk);
		idleCheck = 1'b0;

		repeat (3)
		begin
			issue(randAddr(), 1'b0, bridgePkg::transNonseq, Hwdata, '0);
			settle(Hwdata);
		end
		repeat (4)
		begin
			a1 = randAddr();
			d1 = $random(seed);
			wrAddrs.push_back(a1);
			issue(a1, 1'b1, bridgePkg::transNonseq, Hwdata, d1);
			settle(d1);
		end
		// back-to-back writes with the second one pipelined behind the first
		repeat (3)
		begin
			a1 = randAddr();
			d1 = $random(seed);
			d2 = $random(seed);
			wrAddrs.push_back(a1);
			issue(a1, 1'b1, bridgePkg::transNonseq, Hwdata, d1);
			a1 = randAddr();
			wrAddrs.push_back(a1);
			issue(a1, 1'b1, bridgePkg::transSeq, d1, d2);
			settle(d2);
		end
		foreach (wrAddrs[i])
		begin
			issue(wrAddrs[i], 1'b0, bridgePkg::transNonseq, Hwdata, '0);
			settle(Hwdata);
		end

		// unmapped and busy phases next to real transfers
		d1 = $random(seed);
		issue(randAddr(), 1'b1, bridgePkg::transNonseq, Hwdata, d1);
		issue(32'h1000_0000, 1'b0, bridgePkg::transNonseq, d1, '0);
		settle(d1);
		d1 = $random(seed);
		issue(randAddr(), 1'b1, bridgePkg::transNonseq, Hwdata, d1);
		issue(randAddr(), 1'b1, bridgePkg::transBusy, d1, '0);
		settle(d1);
		issue(32'h8c00_0040, 1'b0, bridgePkg::transNonseq, Hwdata, '0);
		issue(randAddr(), 1'b0, bridgePkg::transNonseq, Hwdata, '0);
		settle(Hwdata);
		issue(randAddr(), 1'b0, bridgePkg::transBusy, Hwdata, '0);
		issue(wrAddrs[0], 1'b0, bridgePkg::transNonseq, Hwdata, '0);
		settle(Hwdata);
		endRun();
	end

endmodule

`default_nettype wire

// ==== compile.f ====
common/bridgePkg.sv
source/ahbSlaveInterface.sv
source/transferPipe.sv
apbController/apbController.sv
source/ahbApbBridge.sv
sim/apbSlaveModel.sv
sim/bridgeTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# builds the bridge testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f compile.f --top-module bridgeTb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/VbridgeTb > sim.log 2>&1
runStatus=$?
cat sim.log
if [ $runStatus -ne 0 ]; then
	echo "simulation exited with status $runStatus"
	exit 1
fi

if grep -qF "** FAIL **" sim.log; then
	exit 1
fi
exit 0
